//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Geometry of the L1 data cache.
// Addresses count words, not bytes.
// Each line holds exactly one word.

// Width of the CPU word address.
`define CACHE_ADDR_W 16

// Width of one data word.
`define CACHE_DATA_W 32

// Width of the line index.
// Six bits give 64 direct-mapped lines.
`define CACHE_INDEX_W 6

// Number of lines in the tag and data stores.
`define CACHE_LINES (1 << `CACHE_INDEX_W)

// The tag is what remains of the address above the index.
`define CACHE_TAG_W (`CACHE_ADDR_W - `CACHE_INDEX_W)

`endif

//--- cache_controller.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_controller (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cpu_cs,
	input  logic                    cpu_we,
	input  mem_pkg::mem_addr_t      cpu_addr,
	output logic                    cpu_ack,
	output cache_pkg::cache_index_t index,
	input  cache_pkg::tag_entry_t   tag_rdata,
	output logic                    tag_we,
	output cache_pkg::tag_entry_t   tag_wdata,
	output logic                    data_we,
	output logic                    fill_sel,
	output logic                    wb_sel,
	output logic                    dram_cs,
	output logic                    dram_we,
	input  logic                    dram_ack
);
	import cache_pkg::*;
	import mem_pkg::*;

	cache_state_t state;
	cache_state_t next_state;

	mem_addr_t    req_addr;
	logic         req_we;
	cache_index_t req_index;
	cache_tag_t   req_tag;
	logic         lookup_ready;
	logic         hit;

	cache_index_t sweep_cnt;
	logic         sweeping;

	assign req_index = req_addr[`CACHE_INDEX_W-1:0];
	assign req_tag   = req_addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
	assign hit       = tag_rdata.valid && (tag_rdata.tag == req_tag);

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= STATE_IDLE;
		end
		else
		begin
			state <= next_state;
		end
	end

	// The request is taken once, at the edge that leaves idle.
	always_ff @(posedge clk)
	begin
		if (state == STATE_IDLE && cpu_cs && !sweeping)
		begin
			req_addr <= cpu_addr;
			req_we   <= cpu_we;
		end
	end

	// High in the second cycle of compare, when the arrays show the request line.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			lookup_ready <= 1'b0;
		end
		else
		begin
			lookup_ready <= (state == STATE_COMPARE) && !lookup_ready;
		end
	end

	// Invalidate every tag entry, one per cycle, after reset.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			sweep_cnt <= '0;
			sweeping  <= 1'b1;
		end
		else if (sweeping)
		begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (sweep_cnt == '1)
			begin
				sweeping <= 1'b0;
			end
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			STATE_IDLE:
			begin
				if (cpu_cs && !sweeping)
				begin
					next_state = STATE_COMPARE;
				end
			end
			STATE_COMPARE:
			begin
				if (lookup_ready)
				begin
					if (hit)
					begin
						next_state = req_we ? STATE_WRITE_HIT : STATE_ACK;
					end
					else if (tag_rdata.valid && tag_rdata.dirty)
					begin
						next_state = STATE_WRITEBACK;
					end
					else
					begin
						next_state = req_we ? STATE_WRITE_INSTALL : STATE_FILL_REQUEST;
					end
				end
			end
			STATE_WRITEBACK:
			begin
				if (dram_ack)
				begin
					next_state = req_we ? STATE_WRITE_INSTALL : STATE_FILL_REQUEST;
				end
			end
			STATE_FILL_REQUEST:
			begin
				next_state = STATE_FILL_DATA;
			end
			STATE_FILL_DATA:
			begin
				if (dram_ack)
				begin
					next_state = STATE_IDLE;
				end
			end
			default:
			begin
				next_state = STATE_IDLE;
			end
		endcase
	end

	// The sweep owns the index until it is done.
	assign index = sweeping ? sweep_cnt : req_index;

	// A fill installs a clean line, a CPU write a dirty one.
	always_comb
	begin
		if (sweeping)
		begin
			tag_wdata = '0;
		end
		else
		begin
			tag_wdata = '{valid: 1'b1, dirty: req_we, tag: req_tag};
		end
	end

	assign data_we = (state == STATE_WRITE_HIT) || (state == STATE_WRITE_INSTALL) ||
	                 (state == STATE_FILL_DATA && dram_ack);
	assign tag_we  = sweeping || data_we;

	assign fill_sel = (state == STATE_FILL_DATA);
	assign wb_sel   = (state == STATE_WRITEBACK);
	assign dram_cs  = (state == STATE_WRITEBACK) || (state == STATE_FILL_DATA);
	assign dram_we  = (state == STATE_WRITEBACK);

	// A read miss is acknowledged together with its fill word.
	assign cpu_ack = (state == STATE_ACK) || (state == STATE_WRITE_HIT) ||
	                 (state == STATE_WRITE_INSTALL) || (state == STATE_FILL_DATA && dram_ack);

	a_ack_single: assert property (
		@(posedge clk) disable iff (!rst) cpu_ack |=> !cpu_ack
	) else $error("cache_controller: cpu_ack held for two cycles");

	a_dram_hold: assert property (
		@(posedge clk) disable iff (!rst) dram_cs && !dram_ack |=> dram_cs
	) else $error("cache_controller: dram_cs dropped before dram_ack");

	// A DRAM write only goes out while the arrays still show a dirty victim.
	a_wb_victim: assert property (
		@(posedge clk) disable iff (!rst)
		dram_we |-> tag_rdata.valid && tag_rdata.dirty && !hit
	) else $error("cache_controller: dram_we without a dirty victim");

endmodule

//--- cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

	// Line index, the low bits of the word address.
	typedef logic [`CACHE_INDEX_W-1:0] cache_index_t;

	// Tag, the high bits of the word address.
	typedef logic [`CACHE_TAG_W-1:0] cache_tag_t;

	// One entry of the tag store.
	typedef struct packed {
		logic       valid;
		logic       dirty;
		cache_tag_t tag;
	} tag_entry_t;

	// Controller states.
	// Compare spends its first cycle waiting for the registered array read.
	typedef enum logic [2:0] {
		STATE_IDLE,
		STATE_COMPARE,
		// Dirty victim goes out to DRAM.
		STATE_WRITEBACK,
		// One quiet cycle on the DRAM bus before the fill.
		STATE_FILL_REQUEST,
		// Fill read held until the DRAM acknowledges.
		STATE_FILL_DATA,
		STATE_WRITE_HIT,
		// Write miss installs the new word over the line.
		STATE_WRITE_INSTALL,
		// Read hit acknowledge.
		STATE_ACK
	} cache_state_t;

endpackage

//--- cache_sram.sv
`timescale 1ns/10ps

module cache_sram #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 2 ** $bits(cache_pkg::cache_index_t)
) (
	input  logic                    clk,
	input  cache_pkg::cache_index_t index,
	input  logic                    we,
	input  entry_t                  wdata,
	output entry_t                  rdata
);

	entry_t mem [DEPTH];

	// Registered read.
	// A read and a write to the same index in one cycle return the old entry.
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[index] <= wdata;
		end
		rdata <= mem[index];
	end

	// A write with an unknown index would corrupt an unknown line.
	a_index_known: assert property (
		@(posedge clk) we |-> !$isunknown(index)
	) else $error("cache_sram: write with unknown index %h", index);

endmodule

//--- l1_cache.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module l1_cache (
	input  logic               clk,
	input  logic               rst,
	input  logic               cpu_cs,
	input  logic               cpu_we,
	input  mem_pkg::mem_addr_t cpu_addr,
	input  mem_pkg::mem_word_t cpu_wdata,
	output logic               cpu_ack,
	output mem_pkg::mem_word_t cpu_rdata,
	output logic               dram_cs,
	output logic               dram_we,
	output mem_pkg::mem_addr_t dram_addr,
	output mem_pkg::mem_word_t dram_wdata,
	input  mem_pkg::mem_word_t dram_rdata,
	input  logic               dram_ack
);
	import cache_pkg::*;
	import mem_pkg::*;

	cache_index_t index;
	tag_entry_t   tag_rdata;
	tag_entry_t   tag_wdata;
	logic         tag_we;
	mem_word_t    data_rdata;
	mem_word_t    data_wdata;
	logic         data_we;
	logic         fill_sel;
	logic         wb_sel;

	cache_controller i_controller (
		.clk       (clk),
		.rst       (rst),
		.cpu_cs    (cpu_cs),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_ack   (cpu_ack),
		.index     (index),
		.tag_rdata (tag_rdata),
		.tag_we    (tag_we),
		.tag_wdata (tag_wdata),
		.data_we   (data_we),
		.fill_sel  (fill_sel),
		.wb_sel    (wb_sel),
		.dram_cs   (dram_cs),
		.dram_we   (dram_we),
		.dram_ack  (dram_ack)
	);

	cache_sram #(
		.entry_t (tag_entry_t),
		.DEPTH   (`CACHE_LINES)
	) i_tag_store (
		.clk   (clk),
		.index (index),
		.we    (tag_we),
		.wdata (tag_wdata),
		.rdata (tag_rdata)
	);

	cache_sram #(
		.entry_t (mem_word_t),
		.DEPTH   (`CACHE_LINES)
	) i_data_store (
		.clk   (clk),
		.index (index),
		.we    (data_we),
		.wdata (data_wdata),
		.rdata (data_rdata)
	);

	// Fills write the DRAM word, everything else writes the CPU word.
	assign data_wdata = fill_sel ? dram_rdata : cpu_wdata;

	// On a read miss the fill word goes straight back to the CPU.
	assign cpu_rdata = fill_sel ? dram_rdata : data_rdata;

	// Writeback address is rebuilt from the victim tag and the line index.
	assign dram_addr  = wb_sel ? {tag_rdata.tag, index} : cpu_addr;
	assign dram_wdata = data_rdata;

endmodule

//--- mem_pkg.sv
`include "cache_cfg.svh"

package mem_pkg;

	// Word address, as seen by both the CPU and the DRAM.
	typedef logic [`CACHE_ADDR_W-1:0] mem_addr_t;

	// One data word.
	// The data store holds these, one per line.
	typedef logic [`CACHE_DATA_W-1:0] mem_word_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the L1 cache testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_l1_cache -f sources.f -o sim_l1_cache > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/sim_l1_cache > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

grep -qx "No errors" sim.log
if [ $? -ne 0 ]; then
	echo "FAIL, see sim.log"
	exit 1
fi

echo "PASS"
exit 0

//--- sources.f
+incdir+.
mem_pkg.sv
cache_pkg.sv
cache_sram.sv
cache_controller.sv
l1_cache.sv
tb_dram_model.sv
tb_l1_cache.sv

//--- tb_dram_model.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tb_dram_model (
	input  logic               clk,
	input  logic               rst,
	input  logic               cs,
	input  logic               we,
	input  mem_pkg::mem_addr_t addr,
	input  mem_pkg::mem_word_t wdata,
	output mem_pkg::mem_word_t rdata,
	output logic               ack
);
	import mem_pkg::*;

	mem_word_t   mem [2 ** `CACHE_ADDR_W];
	logic        busy;
	logic [1:0]  wait_cnt;
	logic [31:0] lfsr_state;
	logic [31:0] lfsr_a;
	logic [31:0] lfsr_b;

	// Galois LFSR, one step per bit taken.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Every word starts with a value built from its whole address.
	initial
	begin
		for (int a = 0; a < 2 ** `CACHE_ADDR_W; a++)
		begin
			mem[a] = {~a[15:0], a[15:0]} ^ 32'h3c96_0f5a;
		end
	end

	assign lfsr_a = lfsr_step(lfsr_state);
	assign lfsr_b = lfsr_step(lfsr_a);

	// A request waits 1 to 4 cycles, then gets a one-cycle acknowledge.
	always @(posedge clk)
	begin
		if (!rst)
		begin
			ack        <= 1'b0;
			busy       <= 1'b0;
			wait_cnt   <= '0;
			lfsr_state <= 32'h69;
		end
		else
		begin
			ack <= 1'b0;
			if (cs && !ack)
			begin
				if (!busy)
				begin
					busy       <= 1'b1;
					wait_cnt   <= {lfsr_a[0], lfsr_b[0]};
					lfsr_state <= lfsr_b;
				end
				else if (wait_cnt == '0)
				begin
					ack  <= 1'b1;
					busy <= 1'b0;
					if (we)
					begin
						mem[addr] <= wdata;
					end
					else
					begin
						rdata <= mem[addr];
					end
				end
				else
				begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

endmodule

//--- tb_l1_cache.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tb_l1_cache;
	import mem_pkg::*;

	localparam int NUM_OPS     = 300;
	localparam int CLK_NS      = 20;
	localparam int ACK_LIMIT   = 200;
	// Drive edge, sampling edge, two edges to the acknowledge, then the half cycle.
	localparam int HIT_NEGEDGES = 4;
	localparam longint WATCHDOG_NS =
		longint'(NUM_OPS) * 20 * CLK_NS + (5 + `CACHE_LINES + 20) * CLK_NS;

	logic      clk;
	logic      rst;
	logic      cpu_cs;
	logic      cpu_we;
	mem_addr_t cpu_addr;
	mem_word_t cpu_wdata;
	logic      cpu_ack;
	mem_word_t cpu_rdata;
	logic      dram_cs;
	logic      dram_we;
	mem_addr_t dram_addr;
	mem_word_t dram_wdata;
	mem_word_t dram_rdata;
	logic      dram_ack;

	int          err_count;
	int          check_count;
	logic [31:0] lfsr_state;
	logic        dram_seen;

	// Shadow models of memory contents and of the tag store.
	mem_word_t   shadow_mem [2 ** `CACHE_ADDR_W];
	logic        sh_valid [`CACHE_LINES];
	logic        sh_dirty [`CACHE_LINES];
	logic [`CACHE_TAG_W-1:0] sh_tag [`CACHE_LINES];

	// DRAM transactions seen during the current operation.
	logic        log_we [$];
	mem_addr_t   log_addr [$];
	mem_word_t   log_data [$];

	l1_cache i_l1_cache (
		.clk        (clk),
		.rst        (rst),
		.cpu_cs     (cpu_cs),
		.cpu_we     (cpu_we),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_ack    (cpu_ack),
		.cpu_rdata  (cpu_rdata),
		.dram_cs    (dram_cs),
		.dram_we    (dram_we),
		.dram_addr  (dram_addr),
		.dram_wdata (dram_wdata),
		.dram_rdata (dram_rdata),
		.dram_ack   (dram_ack)
	);

	tb_dram_model i_dram (
		.clk   (clk),
		.rst   (rst),
		.cs    (dram_cs),
		.we    (dram_we),
		.addr  (dram_addr),
		.wdata (dram_wdata),
		.rdata (dram_rdata),
		.ack   (dram_ack)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_NS / 2) clk = ~clk;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the run did not finish in time");
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] r);
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			err_count++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	// Outputs stay quiet while reset is held.
	always @(negedge clk)
	begin
		if (!rst)
		begin
			check_count++;
			assert (!cpu_ack && !dram_cs && !dram_we)
			else
			begin
				err_count++;
				$display("cpu_ack, dram_cs or dram_we was high during reset");
			end
		end
	end

	// Record every acknowledged DRAM transaction.
	always @(negedge clk)
	begin
		if (rst && dram_cs)
		begin
			dram_seen = 1'b1;
			if (dram_ack)
			begin
				log_we.push_back(dram_we);
				log_addr.push_back(dram_addr);
				log_data.push_back(dram_wdata);
			end
		end
	end

	task automatic run_op(input logic we, input mem_addr_t addr, input mem_word_t wdata);
		logic [`CACHE_INDEX_W-1:0] idx;
		logic [`CACHE_TAG_W-1:0]   tg;
		logic                      hit;
		logic                      dirty_victim;
		logic                      acked;
		mem_addr_t                 victim;
		int                        cycles;
		int                        exp_tx;
		int                        pos;
		idx          = addr[`CACHE_INDEX_W-1:0];
		tg           = addr[`CACHE_ADDR_W-1:`CACHE_INDEX_W];
		hit          = sh_valid[idx] && (sh_tag[idx] == tg);
		dirty_victim = sh_valid[idx] && sh_dirty[idx] && !hit;
		victim       = {sh_tag[idx], idx};
		log_we.delete();
		log_addr.delete();
		log_data.delete();
		dram_seen = 1'b0;
		cycles    = 0;
		@(posedge clk);
		cpu_cs    <= 1'b1;
		cpu_we    <= we;
		cpu_addr  <= addr;
		cpu_wdata <= wdata;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!cpu_ack && cycles < ACK_LIMIT);
		acked = cpu_ack;
		if (!acked)
		begin
			err_count++;
			$display("No acknowledge for the request to address %h", addr);
		end
		else if (!we)
		begin
			check_value("cpu_rdata", cpu_rdata, shadow_mem[addr]);
		end
		// The fill is logged in the acknowledge cycle, so look at the log one edge later.
		@(posedge clk);
		cpu_cs <= 1'b0;
		cpu_we <= 1'b0;
		if (acked)
		begin
			if (hit)
			begin
				check_value("hit latency", cycles, HIT_NEGEDGES);
				check_value("dram_cs on hit", dram_seen, 1'b0);
			end
			else
			begin
				// Writeback first for a dirty victim, then a fill for reads.
				exp_tx = (dirty_victim ? 1 : 0) + (we ? 0 : 1);
				check_value("DRAM transaction count", log_we.size(), exp_tx);
				pos = 0;
				if (dirty_victim && log_we.size() > pos)
				begin
					check_value("dram_we", log_we[pos], 1'b1);
					check_value("dram_addr", log_addr[pos], victim);
					check_value("dram_wdata", log_data[pos], shadow_mem[victim]);
					pos++;
				end
				if (!we && log_we.size() > pos)
				begin
					check_value("dram_we", log_we[pos], 1'b0);
					check_value("dram_addr", log_addr[pos], addr);
				end
			end
		end
		// Write-allocate and write-back rules for the shadow tag model.
		if (we)
		begin
			shadow_mem[addr] = wdata;
		end
		sh_dirty[idx] = hit ? (sh_dirty[idx] | we) : we;
		sh_valid[idx] = 1'b1;
		sh_tag[idx]   = tg;
	endtask

	initial
	begin
		logic [31:0] r_we;
		logic [31:0] r_tag;
		logic [31:0] r_idx;
		logic [31:0] r_data;
		mem_addr_t   addr;
		err_count   = 0;
		check_count = 0;
		lfsr_state  = 32'h69;
		dram_seen   = 1'b0;
		rst       = 1'b0;
		cpu_cs    = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		for (int a = 0; a < 2 ** `CACHE_ADDR_W; a++)
		begin
			shadow_mem[a] = {~a[15:0], a[15:0]} ^ 32'h3c96_0f5a;
		end
		for (int i = 0; i < `CACHE_LINES; i++)
		begin
			sh_valid[i] = 1'b0;
			sh_dirty[i] = 1'b0;
			sh_tag[i]   = '0;
		end
		repeat (5) @(posedge clk);
		rst <= 1'b1;
		// Few tags and few indexes, so lines get evicted often.
		for (int n = 0; n < NUM_OPS; n++)
		begin
			draw_bits(1, r_we);
			draw_bits(2, r_tag);
			draw_bits(3, r_idx);
			draw_bits(32, r_data);
			addr = {r_tag[1:0], 8'hc3, 3'b101, r_idx[2:0]};
			run_op(r_we[0], addr, r_data);
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", check_count, err_count);
		if (err_count == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
